// File: memsys_cfg.svh
`ifndef MEMSYS_CFG_SVH
`define MEMSYS_CFG_SVH

// bus widths
`define ADDR_W 32
`define DATA_W 32
`define STRB_W 4   // one enable per byte lane
`define RESP_W 2

// sram depth in 32-bit words
`define MEM_WORDS 1024

// rdata after reset, a rv32 nop
`define NOP_WORD 32'h00000013

// axi response codes
`define RESP_OKAY 2'd0
`define RESP_SLVERR 2'd2

`endif

// File: memsys_pkg.sv
`include "memsys_cfg.svh"

package memsys_pkg;

    typedef logic [`ADDR_W-1:0] addr_t;  // byte address
    typedef logic [`DATA_W-1:0] data_t;
    typedef logic [`STRB_W-1:0] strb_t;
    typedef logic [`RESP_W-1:0] resp_t;

    typedef enum logic [1:0] {
        ARB_IDLE,
        ARB_BUSY,
        ARB_RELEASE
    } arb_state_t;

    typedef enum logic [1:0] {
        BRG_IDLE,
        BRG_ADDR,
        BRG_WAIT,
        BRG_DONE
    } brg_state_t;

    typedef enum logic [1:0] {
        SRAM_IDLE,
        SRAM_READ,
        SRAM_WRITE
    } sram_state_t;

endpackage

// File: memsys_arbiter.sv
module memsys_arbiter import memsys_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,

    // instruction fetch client (read only)
    input  logic  if_req,
    input  addr_t if_addr,
    output logic  if_ack,
    output data_t if_rdata,
    output logic  if_err,

    // load/store client
    input  logic  ls_req,
    input  logic  ls_we,
    input  addr_t ls_addr,
    input  data_t ls_wdata,
    input  strb_t ls_strb,
    output logic  ls_ack,
    output data_t ls_rdata,
    output logic  ls_err,

    // towards the bridge
    output logic  bus_req,
    output logic  bus_we,
    output addr_t bus_addr,
    output data_t bus_wdata,
    output strb_t bus_strb,
    input  logic  bus_ack,
    input  data_t bus_rdata,
    input  logic  bus_err
);

    arb_state_t state;
    logic       sel_ls;   // current winner is load/store
    logic       last_ls;  // who was served last
    logic       ack_q;
    data_t      rdata_q;
    logic       err_q;
    logic       win_req;

    assign win_req = sel_ls ? ls_req : if_req;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= ARB_IDLE;
            sel_ls  <= 1'b0;
            last_ls <= 1'b1;  // fetch goes first on a tie
            ack_q   <= 1'b0;
            err_q   <= 1'b0;
        end else begin
            case (state)
                ARB_IDLE: begin
                    if (if_req && ls_req) begin
                        sel_ls  <= ~last_ls;
                        last_ls <= ~last_ls;
                        state   <= ARB_BUSY;
                    end else if (if_req || ls_req) begin
                        sel_ls  <= ls_req;
                        last_ls <= ls_req;
                        state   <= ARB_BUSY;
                    end
                end
                ARB_BUSY: begin
                    if (bus_ack) begin
                        rdata_q <= bus_rdata;
                        err_q   <= bus_err;
                        ack_q   <= 1'b1;
                        state   <= ARB_RELEASE;
                    end
                end
                ARB_RELEASE: begin
                    if (!win_req) begin
                        ack_q <= 1'b0;
                    end
                    // bridge must also be back to idle
                    if (!ack_q && !bus_ack) begin
                        state <= ARB_IDLE;
                    end
                end
                default: state <= ARB_IDLE;
            endcase
        end
    end

    assign bus_req   = (state == ARB_BUSY);
    assign bus_we    = sel_ls & ls_we;
    assign bus_addr  = sel_ls ? ls_addr : if_addr;
    assign bus_wdata = sel_ls ? ls_wdata : '0;
    assign bus_strb  = sel_ls ? ls_strb : '0;

    // response goes to the winner only
    assign if_ack   = ack_q & ~sel_ls;
    assign ls_ack   = ack_q & sel_ls;
    assign if_rdata = sel_ls ? '0 : rdata_q;
    assign ls_rdata = sel_ls ? rdata_q : '0;
    assign if_err   = err_q & ~sel_ls;
    assign ls_err   = err_q & sel_ls;

    // new grant only once the bridge has dropped its ack
    a_bus_idle: assert property (@(posedge clk) disable iff (!rst_n)
        $rose(bus_req) |-> !bus_ack);

endmodule

// File: axil_master_bridge.sv
`include "memsys_cfg.svh"

module axil_master_bridge import memsys_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,

    // four-phase side from the arbiter
    input  logic  bus_req,
    input  logic  bus_we,
    input  addr_t bus_addr,
    input  data_t bus_wdata,
    input  strb_t bus_strb,
    output logic  bus_ack,
    output data_t bus_rdata,
    output logic  bus_err,

    // AR
    output addr_t araddr,
    output logic  arvalid,
    input  logic  arready,
    // R
    input  data_t rdata,
    input  resp_t rresp,
    input  logic  rvalid,
    output logic  rready,
    // AW
    output addr_t awaddr,
    output logic  awvalid,
    input  logic  awready,
    // W
    output data_t wdata,
    output strb_t wstrb,
    output logic  wvalid,
    input  logic  wready,
    // B
    input  resp_t bresp,
    input  logic  bvalid,
    output logic  bready
);

    brg_state_t state;
    logic       we_q;
    addr_t      addr_q;
    data_t      wdata_q;
    strb_t      strb_q;
    logic       aw_done;
    logic       w_done;

    // a channel is finished once its valid is gone or being taken
    assign aw_done = !awvalid || awready;
    assign w_done  = !wvalid || wready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= BRG_IDLE;
            we_q    <= 1'b0;
            arvalid <= 1'b0;
            awvalid <= 1'b0;
            wvalid  <= 1'b0;
            bus_ack <= 1'b0;
            bus_err <= 1'b0;
        end else begin
            case (state)
                BRG_IDLE: begin
                    if (bus_req) begin
                        we_q    <= bus_we;
                        addr_q  <= bus_addr;
                        wdata_q <= bus_wdata;
                        strb_q  <= bus_strb;
                        arvalid <= ~bus_we;
                        awvalid <= bus_we;   // aw and w go out together
                        wvalid  <= bus_we;
                        state   <= BRG_ADDR;
                    end
                end
                BRG_ADDR: begin
                    if (we_q) begin
                        if (awvalid && awready) begin
                            awvalid <= 1'b0;
                        end
                        if (wvalid && wready) begin
                            wvalid <= 1'b0;
                        end
                        if (aw_done && w_done) begin
                            state <= BRG_WAIT;
                        end
                    end else if (arready) begin
                        arvalid <= 1'b0;
                        state   <= BRG_WAIT;
                    end
                end
                BRG_WAIT: begin
                    if (rvalid && rready) begin
                        bus_rdata <= rdata;
                        bus_err   <= (rresp != `RESP_OKAY);
                        bus_ack   <= 1'b1;
                        state     <= BRG_DONE;
                    end else if (bvalid && bready) begin
                        bus_rdata <= '0;
                        bus_err   <= (bresp != `RESP_OKAY);
                        bus_ack   <= 1'b1;
                        state     <= BRG_DONE;
                    end
                end
                BRG_DONE: begin
                    if (!bus_req) begin
                        bus_ack <= 1'b0;
                        state   <= BRG_IDLE;
                    end
                end
                default: state <= BRG_IDLE;
            endcase
        end
    end

    assign araddr = addr_q;
    assign awaddr = addr_q;
    assign wdata  = wdata_q;
    assign wstrb  = strb_q;
    assign rready = (state == BRG_WAIT) && !we_q;
    assign bready = (state == BRG_WAIT) && we_q;

    a_ar_hold: assert property (@(posedge clk) disable iff (!rst_n)
        arvalid && !arready |=> arvalid && $stable(araddr));

endmodule

// File: axil_sram.sv
`include "memsys_cfg.svh"

module axil_sram import memsys_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,

    // AR
    input  addr_t araddr,
    input  logic  arvalid,
    output logic  arready,
    // R
    output data_t rdata,
    output resp_t rresp,
    output logic  rvalid,
    input  logic  rready,
    // AW
    input  addr_t awaddr,
    input  logic  awvalid,
    output logic  awready,
    // W
    input  data_t wdata,
    input  strb_t wstrb,
    input  logic  wvalid,
    output logic  wready,
    // B
    output resp_t bresp,
    output logic  bvalid,
    input  logic  bready
);

    localparam int IDX_W = $clog2(`MEM_WORDS);

    data_t mem [`MEM_WORDS];

    sram_state_t      state;
    logic [2:0]       lfsr;      // nonzero delay source
    logic [2:0]       wait_cnt;
    logic             done;      // response pending
    logic [IDX_W-1:0] idx_q;
    logic             in_range_q;
    data_t            wdata_q;
    strb_t            wstrb_q;
    logic             rd_hs;
    logic             wr_hs;
    logic             fire;

    assign arready = (state == SRAM_IDLE);
    assign awready = (state == SRAM_IDLE);
    assign wready  = (state == SRAM_IDLE);

    assign rd_hs = arvalid && arready;
    assign wr_hs = awvalid && awready && wvalid && wready;  // both or nothing
    assign fire  = (state != SRAM_IDLE) && !done && (wait_cnt == lfsr);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state    <= SRAM_IDLE;
            lfsr     <= 3'b001;
            wait_cnt <= 3'd0;
            done     <= 1'b0;
            rdata    <= `NOP_WORD;
        end else begin
            case (state)
                SRAM_IDLE: begin
                    lfsr     <= {lfsr[1:0], lfsr[2] ^ lfsr[1]};
                    wait_cnt <= 3'd1;  // handshake cycle counts as one
                    done     <= 1'b0;
                    if (rd_hs) begin
                        idx_q      <= araddr[IDX_W+1:2];
                        in_range_q <= (araddr[`ADDR_W-1:2] < `MEM_WORDS);
                        state      <= SRAM_READ;
                    end else if (wr_hs) begin
                        idx_q      <= awaddr[IDX_W+1:2];
                        in_range_q <= (awaddr[`ADDR_W-1:2] < `MEM_WORDS);
                        wdata_q    <= wdata;
                        wstrb_q    <= wstrb;
                        state      <= SRAM_WRITE;
                    end
                end
                SRAM_READ: begin
                    if (fire) begin
                        rdata <= in_range_q ? mem[idx_q] : '0;
                        done  <= 1'b1;
                    end else if (!done) begin
                        wait_cnt <= wait_cnt + 3'd1;
                    end
                    if (rvalid && rready) begin
                        state <= SRAM_IDLE;
                    end
                end
                SRAM_WRITE: begin
                    if (fire) begin
                        done <= 1'b1;  // memory updated in the block below
                    end else if (!done) begin
                        wait_cnt <= wait_cnt + 3'd1;
                    end
                    if (bvalid && bready) begin
                        state <= SRAM_IDLE;
                    end
                end
                default: state <= SRAM_IDLE;
            endcase
        end
    end

    // per-lane write that skips out of range words
    always_ff @(posedge clk) begin
        if (state == SRAM_WRITE && fire && in_range_q) begin
            for (int b = 0; b < `STRB_W; b++) begin
                if (wstrb_q[b]) begin
                    mem[idx_q][8*b +: 8] <= wdata_q[8*b +: 8];
                end
            end
        end
    end

    assign rvalid = (state == SRAM_READ) && done;
    assign bvalid = (state == SRAM_WRITE) && done;
    assign rresp  = in_range_q ? `RESP_OKAY : `RESP_SLVERR;
    assign bresp  = in_range_q ? `RESP_OKAY : `RESP_SLVERR;

    // the write handshake needs aw and w offered together
    a_aw_with_w: assert property (@(posedge clk) disable iff (!rst_n)
        awvalid |-> wvalid);

endmodule

// File: memsys_top.sv
module memsys_top import memsys_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,

    input  logic  if_req,
    input  addr_t if_addr,
    output logic  if_ack,
    output data_t if_rdata,
    output logic  if_err,

    input  logic  ls_req,
    input  logic  ls_we,
    input  addr_t ls_addr,
    input  data_t ls_wdata,
    input  strb_t ls_strb,
    output logic  ls_ack,
    output data_t ls_rdata,
    output logic  ls_err
);

    // arbiter to bridge
    logic  bus_req;
    logic  bus_we;
    addr_t bus_addr;
    data_t bus_wdata;
    strb_t bus_strb;
    logic  bus_ack;
    data_t bus_rdata;
    logic  bus_err;

    // axi-lite between bridge and sram
    addr_t araddr;
    logic  arvalid;
    logic  arready;
    data_t rdata;
    resp_t rresp;
    logic  rvalid;
    logic  rready;
    addr_t awaddr;
    logic  awvalid;
    logic  awready;
    data_t wdata;
    strb_t wstrb;
    logic  wvalid;
    logic  wready;
    resp_t bresp;
    logic  bvalid;
    logic  bready;

    memsys_arbiter u_arbiter (
        .clk       (clk),
        .rst_n     (rst_n),
        .if_req    (if_req),
        .if_addr   (if_addr),
        .if_ack    (if_ack),
        .if_rdata  (if_rdata),
        .if_err    (if_err),
        .ls_req    (ls_req),
        .ls_we     (ls_we),
        .ls_addr   (ls_addr),
        .ls_wdata  (ls_wdata),
        .ls_strb   (ls_strb),
        .ls_ack    (ls_ack),
        .ls_rdata  (ls_rdata),
        .ls_err    (ls_err),
        .bus_req   (bus_req),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_strb  (bus_strb),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata),
        .bus_err   (bus_err)
    );

    axil_master_bridge u_bridge (
        .clk       (clk),
        .rst_n     (rst_n),
        .bus_req   (bus_req),
        .bus_we    (bus_we),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_strb  (bus_strb),
        .bus_ack   (bus_ack),
        .bus_rdata (bus_rdata),
        .bus_err   (bus_err),
        .araddr    (araddr),
        .arvalid   (arvalid),
        .arready   (arready),
        .rdata     (rdata),
        .rresp     (rresp),
        .rvalid    (rvalid),
        .rready    (rready),
        .awaddr    (awaddr),
        .awvalid   (awvalid),
        .awready   (awready),
        .wdata     (wdata),
        .wstrb     (wstrb),
        .wvalid    (wvalid),
        .wready    (wready),
        .bresp     (bresp),
        .bvalid    (bvalid),
        .bready    (bready)
    );

    axil_sram u_sram (
        .clk     (clk),
        .rst_n   (rst_n),
        .araddr  (araddr),
        .arvalid (arvalid),
        .arready (arready),
        .rdata   (rdata),
        .rresp   (rresp),
        .rvalid  (rvalid),
        .rready  (rready),
        .awaddr  (awaddr),
        .awvalid (awvalid),
        .awready (awready),
        .wdata   (wdata),
        .wstrb   (wstrb),
        .wvalid  (wvalid),
        .wready  (wready),
        .bresp   (bresp),
        .bvalid  (bvalid),
        .bready  (bready)
    );

endmodule

// File: tb_memsys.sv
`include "memsys_cfg.svh"

module tb_memsys import memsys_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int TIMEOUT = 200;  // cycles per wait

    logic  clk;
    logic  rst_n;
    logic  if_req;
    addr_t if_addr;
    logic  if_ack;
    data_t if_rdata;
    logic  if_err;
    logic  ls_req;
    logic  ls_we;
    addr_t ls_addr;
    data_t ls_wdata;
    strb_t ls_strb;
    logic  ls_ack;
    data_t ls_rdata;
    logic  ls_err;

    int    error_count;
    int    test_count;
    logic  if_ack_q;
    logic  ls_ack_q;
    logic  if_req_q;
    logic  ls_req_q;

    memsys_top uut (
        .clk      (clk),
        .rst_n    (rst_n),
        .if_req   (if_req),
        .if_addr  (if_addr),
        .if_ack   (if_ack),
        .if_rdata (if_rdata),
        .if_err   (if_err),
        .ls_req   (ls_req),
        .ls_we    (ls_we),
        .ls_addr  (ls_addr),
        .ls_wdata (ls_wdata),
        .ls_strb  (ls_strb),
        .ls_ack   (ls_ack),
        .ls_rdata (ls_rdata),
        .ls_err   (ls_err)
    );

    always #20 clk = ~clk;

    // handshake watch on the values from before this edge
    always @(posedge clk) begin
        if (rst_n) begin
            if (if_ack && ls_ack) begin
                $display("both client acks are high at %0t", $time);
                error_count++;
            end
            if (if_ack && !if_ack_q && !if_req_q) begin
                $display("fetch ack rose without a request at %0t", $time);
                error_count++;
            end
            if (ls_ack && !ls_ack_q && !ls_req_q) begin
                $display("load/store ack rose without a request at %0t", $time);
                error_count++;
            end
        end
        if_ack_q <= if_ack;
        ls_ack_q <= ls_ack;
        if_req_q <= if_req;
        ls_req_q <= ls_req;
    end

    function automatic logic ack_of(input int port);
        return (port == 0) ? if_ack : ls_ack;
    endfunction

    task automatic check_val(input string name, input data_t got, input data_t exp);
        if (got !== exp) begin
            $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
            error_count++;
        end
    endtask

    // one four-phase exchange starting on a falling edge
    task automatic client_access(input int port, input logic we, input addr_t addr,
                                 input data_t wdata, input strb_t strb,
                                 output data_t rdata, output logic err);
        int n;
        n = 0;
        rdata = '0;
        err = 1'b0;
        if (port == 0) begin
            if_addr = addr;
            if_req  = 1'b1;
        end else begin
            ls_we    = we;
            ls_addr  = addr;
            ls_wdata = wdata;
            ls_strb  = strb;
            ls_req   = 1'b1;
        end
        while (!ack_of(port) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ack_of(port)) begin
            rdata = (port == 0) ? if_rdata : ls_rdata;
            err   = (port == 0) ? if_err : ls_err;
        end else begin
            $display("timeout: port %0d got no ack for address %h", port, addr);
            error_count++;
        end
        if (port == 0) begin
            if_req = 1'b0;
        end else begin
            ls_req = 1'b0;
        end
        n = 0;
        while (ack_of(port) && n < TIMEOUT) begin
            @(negedge clk);
            n++;
        end
        if (ack_of(port)) begin
            $display("timeout: port %0d kept ack high after its request fell", port);
            error_count++;
        end
    endtask

    task automatic run_test(input int port, input logic we, input addr_t addr,
                            input data_t wdata, input strb_t strb,
                            input data_t exp_rdata, input logic exp_err);
        int    errs_before;
        data_t got_rdata;
        logic  got_err;
        string pname;
        errs_before = error_count;
        pname = (port == 0) ? "if" : "ls";
        client_access(port, we, addr, wdata, strb, got_rdata, got_err);
        check_val({pname, "_rdata"}, got_rdata, exp_rdata);
        check_val({pname, "_err"}, data_t'(got_err), data_t'(exp_err));
        test_count++;
        $display("test %0d %s %s %h: %s", test_count, pname, we ? "write" : "read", addr,
                 (error_count == errs_before) ? "ok" : "FAIL");
    endtask

    initial begin
        int    fd;
        int    cnt;
        string line;
        int    port;
        int    we;
        int    err_i;
        addr_t addr_v;
        data_t wdata_v;
        strb_t strb_v;
        data_t exp_v;
        logic  pend;      // fetch waiting for its partner line
        addr_t pend_addr;
        data_t pend_exp;
        logic  pend_err;

        clk = 1'b0;
        rst_n = 1'b0;
        if_req = 1'b0;
        if_addr = '0;
        ls_req = 1'b0;
        ls_we = 1'b0;
        ls_addr = '0;
        ls_wdata = '0;
        ls_strb = '0;
        error_count = 0;
        test_count = 0;
        pend = 1'b0;
        void'($urandom(84));

        fd = $fopen("memsys_patterns.txt", "r");
        if (fd == 0) begin
            $display("cannot open memsys_patterns.txt");
            error_count++;
        end else begin
            repeat (4) @(negedge clk);
            rst_n = 1'b1;
            @(negedge clk);
            while (!$feof(fd)) begin
                line = "";
                cnt = $fgets(line, fd);
                if (cnt > 0 && line.len() > 1 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%d %d %h %h %h %h %d", port, we, addr_v,
                                  wdata_v, strb_v, exp_v, err_i);
                    if (cnt != 7 || port > 2 || (pend && port != 1)) begin
                        $display("bad pattern line: %s", line);
                        error_count++;
                    end else if (port == 2) begin
                        pend      = 1'b1;
                        pend_addr = addr_v;
                        pend_exp  = exp_v;
                        pend_err  = (err_i != 0);
                    end else begin
                        if (pend) begin
                            // both clients raise req on the same edge
                            fork
                                run_test(0, 1'b0, pend_addr, '0, '0, pend_exp, pend_err);
                                run_test(1, (we != 0), addr_v, wdata_v, strb_v, exp_v,
                                         (err_i != 0));
                            join
                            pend = 1'b0;
                        end else begin
                            run_test(port, (we != 0), addr_v, wdata_v, strb_v, exp_v,
                                     (err_i != 0));
                        end
                        repeat ($urandom_range(0, 3)) @(negedge clk);  // idle gap
                    end
                end
            end
            $fclose(fd);
            if (test_count == 0) begin
                $display("no tests were read from the pattern file");
                error_count++;
            end
        end

        $display("%0d tests, %0d errors", test_count, error_count);
        if (error_count == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: memsys_patterns.txt
# port we addr wdata strb exp_rdata exp_err  (addr, wdata, strb, rdata in hex)
# port 0 fetch, 1 load/store, 2 fetch raised together with the next load/store line
# full-word writes
1 1 00000000 00000013 f 00000000 0
1 1 00000004 deadbeef f 00000000 0
1 1 00000008 12345678 f 00000000 0
1 1 00000ffc cafef00d f 00000000 0
1 1 00000100 a5a5a5a5 f 00000000 0
# read back from both ports
0 0 00000000 00000000 0 00000013 0
1 0 00000004 00000000 0 deadbeef 0
0 0 00000008 00000000 0 12345678 0
1 0 00000ffc 00000000 0 cafef00d 0
0 0 00000ffc 00000000 0 cafef00d 0
# byte and halfword strobes
1 1 00000100 000000ff 1 00000000 0
1 1 00000100 11223344 4 00000000 0
1 1 00000100 beef0000 c 00000000 0
1 0 00000100 00000000 0 beefa5ff 0
0 0 00000100 00000000 0 beefa5ff 0
1 1 00000008 0000abcd 3 00000000 0
1 1 00000008 99000000 8 00000000 0
1 1 00000008 ffffffff 0 00000000 0
0 0 00000008 00000000 0 9934abcd 0
# out of range, word 0 must survive
1 1 00001000 ffffffff f 00000000 1
1 0 00001000 00000000 0 00000000 1
0 0 00001004 00000000 0 00000000 1
1 1 80000000 12345678 f 00000000 1
0 0 00000000 00000000 0 00000013 0
1 0 00000000 00000000 0 00000013 0
# both clients at once
2 0 00000004 00000000 0 deadbeef 0
1 0 00000008 00000000 0 9934abcd 0
2 0 00000ffc 00000000 0 cafef00d 0
1 1 00000010 0badf00d f 00000000 0
1 0 00000010 00000000 0 0badf00d 0
2 0 00000010 00000000 0 0badf00d 0
1 1 00000004 000000aa 1 00000000 0
1 0 00000004 00000000 0 deadbeaa 0

// File: memsys.f
+incdir+.
memsys_pkg.sv
memsys_arbiter.sv
axil_master_bridge.sv
axil_sram.sv
memsys_top.sv
tb_memsys.sv

// File: Makefile
VERILATOR := verilator
VFLAGS    := --binary -j 0 --assert --timescale 1ns/100ps
TOP       := tb_memsys
FILELIST  := memsys.f
OBJ_DIR   := obj_dir
LOG       := sim.log

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(wildcard *.sv) $(wildcard *.svh)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# the log decides the result, not the exit status of the simulation
run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -q "Regression failed" $(LOG); then exit 1; fi
	@grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
